/* logic/uartPkg.sv */
package uartPkg;

	// system clock, matches the 8 ns bench clock
	localparam int ClkFrequency = 125_000_000;

	// serial line rate
	localparam int Baud = 921_600;

	// tick generator accumulator, one carry bit on top
	localparam int AccWidth = 16;

	// increment = round(Baud*8 * 2^AccWidth / ClkFrequency)
	// 64-bit math, the product overflows 32 bits
	localparam longint TickIncWide =
		((longint'(Baud) * 8 << AccWidth) + longint'(ClkFrequency) / 2) /
		longint'(ClkFrequency);
	localparam logic [AccWidth:0] TickInc = TickIncWide[AccWidth:0];

	// receive lanes and the width of a lane index
	localparam int NumLanes = 4;
	localparam int LaneIdWidth = 2;

	// spacing count at which a bit gets sampled
	// a clean line works with anything from 8 to 11
	localparam int SampleSpacing = 10;

	// idle threshold in ticks, two bit times at 8x oversampling
	localparam int GapTicks = 16;

endpackage

/* logic/baudTickGen.sv */
module baudTickGen (
	input  logic clk,
	input  logic reset,
	output logic tick
);
	import uartPkg::*;

	logic [AccWidth:0] acc; // top bit is the carry out

	// fractional divider
	// the low bits keep the remainder, the carry fires once per 1/(8*Baud) on average
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
		end
		else
		begin
			acc <= {1'b0, acc[AccWidth-1:0]} + TickInc; // drop old carry, add step
		end
	end

	assign tick = acc[AccWidth]; // one cycle wide, carry never holds two cycles

endmodule

/* logic/rxLane.sv */
module rxLane (
	input  logic       clk,
	input  logic       reset,
	input  logic       tick,
	input  logic       rxd,
	output logic [7:0] data,
	output logic       dataReady,
	output logic       frameError,
	output logic       idle,
	output logic       packetEnd
);
	import uartPkg::*;

	logic [1:0] syncInv;    // two-stage sync of the inverted line
	logic [1:0] filterCnt;  // saturating majority counter
	logic       bitInv;     // filtered bit, still inverted
	logic [3:0] state;      // frame state
	logic [3:0] bitSpacing; // ticks inside the current bit
	logic       nextBit;    // sample point of the current bit
	logic       stopSample; // tick that samples the stop bit
	logic [4:0] gapCount;   // ticks since the last frame ended

	// line idles high, inverted it idles at zero
	// so the filter starts out agreeing with an idle line and no phantom start shows up
	always_ff @(posedge clk)
	begin
		if (reset)
			syncInv <= 2'b00;
		else if (tick)
			syncInv <= {syncInv[0], ~rxd};
	end

	// counter climbs while the line reads 1, falls while 0
	// output only flips at the rails, so a single-tick glitch never gets through
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			filterCnt <= 2'b00;
			bitInv    <= 1'b0;
		end
		else if (tick)
		begin
			if (syncInv[1] && filterCnt != 2'b11)
				filterCnt <= filterCnt + 2'd1;
			else if (!syncInv[1] && filterCnt != 2'b00)
				filterCnt <= filterCnt - 2'd1;

			if (filterCnt == 2'b00)
				bitInv <= 1'b0;
			else if (filterCnt == 2'b11)
				bitInv <= 1'b1;
		end
	end

	assign nextBit = (bitSpacing == 4'(SampleSpacing));

	// first sample SampleSpacing ticks after the start was seen
	// after that bit 3 sticks and the low bits roll, so samples come every 8 ticks
	always_ff @(posedge clk)
	begin
		if (reset || state == 4'b0000)
			bitSpacing <= 4'b0000;
		else if (tick)
			bitSpacing <= (bitSpacing[2:0] + 4'd1) | {bitSpacing[3], 3'b000};
	end

	// 0000 idle, 1000..1111 data bits, 0001 stop, 0010 low line after a bad stop
	// state[3] set means a data bit is sampled on the way out
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= 4'b0000;
		end
		else if (tick)
		begin
			case (state)
				4'b0000: if (bitInv) state <= 4'b1000;  // falling edge of start
				4'b1000: if (nextBit) state <= 4'b1001; // bit0 sampled
				4'b1001: if (nextBit) state <= 4'b1010;
				4'b1010: if (nextBit) state <= 4'b1011;
				4'b1011: if (nextBit) state <= 4'b1100;
				4'b1100: if (nextBit) state <= 4'b1101;
				4'b1101: if (nextBit) state <= 4'b1110;
				4'b1110: if (nextBit) state <= 4'b1111;
				4'b1111: if (nextBit) state <= 4'b0001; // bit7 sampled
				4'b0001: if (nextBit) state <= bitInv ? 4'b0010 : 4'b0000; // stop sampled
				4'b0010: if (!bitInv) state <= 4'b0000; // wait for the line to go high again
				default: state <= 4'b0000;
			endcase
		end
	end

	// LSB first, so every new bit enters at the top
	always_ff @(posedge clk)
	begin
		if (tick && nextBit && state[3])
			data <= {~bitInv, data[7:1]};
	end

	assign stopSample = tick && nextBit && (state == 4'b0001);

	// registered, one cycle after the stop sample tick
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dataReady  <= 1'b0;
			frameError <= 1'b0;
		end
		else
		begin
			dataReady  <= stopSample && !bitInv; // stop bit high
			frameError <= stopSample && bitInv;  // stop bit missing
		end
	end

	// gap counter held at zero during a frame, saturates at GapTicks
	always_ff @(posedge clk)
	begin
		if (reset || state != 4'b0000)
			gapCount <= 5'd0;
		else if (tick && gapCount != 5'(GapTicks))
			gapCount <= gapCount + 5'd1;
	end

	assign idle = (gapCount == 5'(GapTicks));

	// fires on the tick that takes the count to GapTicks, i.e. as idle goes high
	always_ff @(posedge clk)
	begin
		if (reset)
			packetEnd <= 1'b0;
		else
			packetEnd <= tick && (gapCount == 5'(GapTicks - 1));
	end

endmodule

/* logic/rxCollector.sv */
module rxCollector (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [uartPkg::NumLanes-1:0]        laneReady,
	input  logic [uartPkg::NumLanes-1:0]        laneError,
	input  logic [uartPkg::NumLanes-1:0][7:0]   laneData,
	output logic                                outValid,
	output logic [uartPkg::LaneIdWidth-1:0]     outLane,
	output logic [7:0]                          outData,
	output logic                                outError
);
	import uartPkg::*;

	logic [NumLanes-1:0][7:0]   holdData; // one byte slot per lane
	logic [NumLanes-1:0]        holdErr;  // slot holds a framing error
	logic [NumLanes-1:0]        holdFull; // slot waiting to drain
	logic [LaneIdWidth-1:0]     ptr;      // round-robin start point
	logic [LaneIdWidth-1:0]     sel;      // lane served this cycle
	logic                       found;

	// first full slot at or after ptr, wrapping around
	always_comb
	begin
		logic [LaneIdWidth-1:0] idx;
		found = 1'b0;
		sel   = ptr;
		idx   = ptr;
		for (int i = 0; i < NumLanes; i++)
		begin
			idx = ptr + LaneIdWidth'(i); // wraps, NumLanes is a power of two
			if (!found && holdFull[idx])
			begin
				found = 1'b1;
				sel   = idx;
			end
		end
	end

	// output straight from the slots, one cycle after the lane pulse at best
	assign outValid = found;
	assign outLane  = sel;
	assign outData  = holdData[sel];
	assign outError = holdErr[sel];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			holdFull <= '0;
			ptr      <= '0;
		end
		else
		begin
			if (found)
			begin
				holdFull[sel] <= 1'b0;
				ptr           <= sel + 1'b1; // served lane goes to the back
			end
			for (int i = 0; i < NumLanes; i++)
			begin
				if (laneReady[i] || laneError[i])
					holdFull[i] <= 1'b1; // a new result wins over the clear
			end
		end
	end

	// payload side, loaded with the pulse
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NumLanes; i++)
		begin
			if (laneReady[i] || laneError[i])
			begin
				holdData[i] <= laneData[i];
				holdErr[i]  <= laneError[i];
			end
		end
	end

endmodule

/* logic/uartRxTop.sv */
module uartRxTop (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [uartPkg::NumLanes-1:0]    rxd,
	output logic                            outValid,
	output logic [uartPkg::LaneIdWidth-1:0] outLane,
	output logic [7:0]                      outData,
	output logic                            outError,
	output logic [uartPkg::NumLanes-1:0]    idle,
	output logic [uartPkg::NumLanes-1:0]    packetEnd
);
	import uartPkg::*;

	logic                     tick;      // shared 8x oversampling tick
	logic [NumLanes-1:0]      laneReady;
	logic [NumLanes-1:0]      laneError;
	logic [NumLanes-1:0][7:0] laneData;

	baudTickGen tickGen (
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	// one receiver per serial line, all on the same tick
	for (genvar i = 0; i < NumLanes; i++)
	begin : lanes
		rxLane lane (
			.clk        (clk),
			.reset      (reset),
			.tick       (tick),
			.rxd        (rxd[i]),
			.data       (laneData[i]),
			.dataReady  (laneReady[i]),
			.frameError (laneError[i]),
			.idle       (idle[i]),
			.packetEnd  (packetEnd[i])
		);
	end

	rxCollector collector (
		.clk       (clk),
		.reset     (reset),
		.laneReady (laneReady),
		.laneError (laneError),
		.laneData  (laneData),
		.outValid  (outValid),
		.outLane   (outLane),
		.outData   (outData),
		.outError  (outError)
	);

endmodule

/* bench/clockGen.sv */
module clockGen (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;
	import uartPkg::*;

	initial
	begin
		clk   = 1'b0;
		reset = 1'b1;
		repeat (16) @(posedge clk); // reset held for 16 cycles
		#1;
		reset = 1'b0; // released with the other inputs, 1 ns after the edge
	end

	always #(1_000_000_000 / ClkFrequency / 2) clk = ~clk; // 8 ns period at 125 MHz

endmodule

/* bench/uartRxBench.sv */
module uartRxBench;
	timeunit 1ns;
	timeprecision 100ps;
	import uartPkg::*;

	logic                   clk;
	logic                   reset;
	logic [NumLanes-1:0]    rxd;
	logic                   outValid;
	logic [LaneIdWidth-1:0] outLane;
	logic [7:0]             outData;
	logic                   outError;
	logic [NumLanes-1:0]    idle;
	logic [NumLanes-1:0]    packetEnd;

	int         bitCycles;               // one bit time in clock cycles
	int         watchdogNs = 0;          // set once the testdata is read
	logic       linesActive;             // first start bit has gone out
	int         frameLane [$];
	logic [7:0] frameByte [$];
	logic       frameStop [$];
	int         frameGap [$];            // idle bit times after each frame
	logic [8:0] expQ [NumLanes][$];      // {error, byte} per lane, file order
	int         endCount [NumLanes];     // packetEnd pulses seen
	int         endExpect [NumLanes];

	clockGen clocks (
		.clk   (clk),
		.reset (reset)
	);

	uartRxTop UUT (
		.clk       (clk),
		.reset     (reset),
		.rxd       (rxd),
		.outValid  (outValid),
		.outLane   (outLane),
		.outData   (outData),
		.outError  (outError),
		.idle      (idle),
		.packetEnd (packetEnd)
	);

	task automatic stopRun(string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	// columns: lane, byte in hex, stop level, gap in bit times
	task automatic loadFrames();
		int    fd;
		int    lane;
		int    byteVal;
		int    stop;
		int    gap;
		int    totalBits;
		string line;
		totalBits = 0;
		fd = $fopen("bench/testdata.txt", "r");
		assert (fd != 0) else stopRun("could not open bench/testdata.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line[0] != "#" &&
				$sscanf(line, "%d %h %d %d", lane, byteVal, stop, gap) == 4)
			begin
				assert (lane >= 0 && lane < NumLanes && (stop == 0 || stop == 1))
					else stopRun($sformatf("bad testdata line: %s", line));
				assert (gap == 0 || gap >= 3)
					else stopRun("testdata gap of 1 or 2 bit times has no defined packet end");
				assert (stop == 1 || gap > 0)
					else stopRun("testdata frame with a low stop bit needs a high gap behind it");
				frameLane.push_back(lane);
				frameByte.push_back(byteVal[7:0]);
				frameStop.push_back(stop[0]);
				frameGap.push_back(gap);
				expQ[lane].push_back({~stop[0], byteVal[7:0]});
				if (gap >= 3)
					endExpect[lane] = endExpect[lane] + 1;
				totalBits = totalBits + 10 + gap;
			end
		end
		$fclose(fd);
		// every frame of every lane back to back, plus startup and settling
		watchdogNs = (totalBits + 25) * bitCycles * (1_000_000_000 / ClkFrequency);
	endtask

	task automatic holdLine(int lane, logic level, int bits);
		rxd[lane] = level;
		repeat (bits * bitCycles) @(posedge clk);
		#1; // next change again 1 ns after an edge
	endtask

	task automatic sendFrame(int lane, logic [7:0] value, logic stop, int gap);
		holdLine(lane, 1'b0, 1); // start bit
		for (int b = 0; b < 8; b++)
			holdLine(lane, value[b], 1); // LSB first
		holdLine(lane, stop, 1);
		if (gap > 0)
			holdLine(lane, 1'b1, gap);
	endtask

	task automatic driveLane(int lane);
		for (int i = 0; i < frameLane.size(); i++)
		begin
			if (frameLane[i] == lane)
				sendFrame(lane, frameByte[i], frameStop[i], frameGap[i]);
		end
	endtask

	// collector output, checked against the lane's queue
	always @(negedge clk)
	begin
		logic [8:0] expected;
		string      testName;
		if (!reset && outValid)
		begin
			assert (linesActive) else stopRun("a result came out before any start bit was sent");
			assert (expQ[outLane].size() > 0)
				else stopRun($sformatf("lane %0d gave a result that was not expected", outLane));
			expected = expQ[outLane].pop_front();
			testName = expected[8] ? "framing error" : "good frame";
			assert (outData === expected[7:0])
				else stopRun($sformatf("FAILED %s data on lane %0d: expected %h, actual %h",
					testName, outLane, expected[7:0], outData));
			assert (outError === expected[8])
				else stopRun($sformatf("FAILED %s flag on lane %0d: expected %b, actual %b",
					testName, outLane, expected[8], outError));
		end
	end

	always @(negedge clk)
	begin
		for (int l = 0; l < NumLanes; l++)
		begin
			if (!reset && packetEnd[l])
			begin
				assert (idle[l]) else stopRun($sformatf("packetEnd on lane %0d with idle low", l));
				endCount[l] = endCount[l] + 1;
			end
		end
	end

	initial
	begin
		wait (watchdogNs > 0);
		#(watchdogNs);
		stopRun("the run timed out before all frames were sent and checked");
	end

	initial
	begin
		int endErrors;
		endErrors   = 0;
		rxd         = '1; // lines idle high through reset
		linesActive = 1'b0;
		bitCycles   = (ClkFrequency + Baud / 2) / Baud;
		for (int l = 0; l < NumLanes; l++)
		begin
			endCount[l]  = 0;
			endExpect[l] = 1; // gap counter also runs out once after reset
		end
		loadFrames();

		wait (reset === 1'b0);
		@(negedge clk);
		assert (idle === '0 && outValid === 1'b0)
			else stopRun("idle or outValid was active right after reset");
		repeat (3 * bitCycles) @(posedge clk); // past GapTicks on an idle line
		@(negedge clk);
		assert (idle === '1)
			else stopRun($sformatf("FAILED reset startup idle: expected %b, actual %b",
				{NumLanes{1'b1}}, idle));

		@(posedge clk);
		#1;
		linesActive = 1'b1;
		for (int l = 0; l < NumLanes; l++)
		begin
			automatic int lane = l;
			fork
				driveLane(lane); // all lanes start on the same edge
			join_none
		end
		wait fork;
		repeat (2 * bitCycles) @(posedge clk); // last result and packet end settle
		@(negedge clk);

		for (int l = 0; l < NumLanes; l++)
		begin
			assert (expQ[l].size() == 0)
			else
			begin
				$display("lane %0d missed %0d results", l, expQ[l].size());
				endErrors = endErrors + 1;
			end
			assert (endCount[l] == endExpect[l])
			else
			begin
				$display("FAILED packet end count on lane %0d: expected %0d, actual %0d",
					l, endExpect[l], endCount[l]);
				endErrors = endErrors + 1;
			end
		end
		if (endErrors == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			stopRun("end of run checks found missing results");
		end
	end

endmodule

/* bench/testdata.txt */
# lane byte stop gap : lane 0..3, byte in hex, stop level 1 good or 0 broken
# gap is the idle high time after the frame in bit times (0, or 3 and up)
0 a5 1 0
1 5a 1 0
2 00 1 0
3 ff 1 0
0 55 1 4
1 c3 1 3
2 01 1 5
3 80 1 0
0 3c 0 14
1 7e 1 0
2 aa 1 3
3 0f 1 4
0 a5 1 3
1 ff 0 14
1 12 1 3
2 e7 1 0
2 99 1 4
3 00 0 14
3 34 1 3
0 f0 1 6

/* compile.f */
logic/uartPkg.sv
logic/baudTickGen.sv
logic/rxLane.sv
logic/rxCollector.sv
logic/uartRxTop.sv
bench/clockGen.sv
bench/uartRxBench.sv

/* run.sh */
#!/usr/bin/env bash
# builds the UART receive testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module uartRxBench -f compile.f -o uartRxSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/uartRxSim > "$log" 2>&1
simStatus=$?
cat "$log"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^All tests passed$" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
